//--- build.f
design/fml_pkg.sv
design/pix_pkg.sv
design/dst_addr_gen.sv
design/dst_line_fetch.sv
design/dst_blend.sv
design/dst_fetch_top.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- design/dst_addr_gen.sv
// address stage; fml_depth must be at most 26 and the address wraps silently past the end of memory
module dst_addr_gen import pix_pkg::*; #(
	parameter int fml_depth = 26
) (
	input logic sys_clk,
	input logic sys_rst,

	input logic in_stb_i,
	output logic in_ack_o,
	input pix_xy_t in_pix_i,

	input logic [fml_depth-2:0] fb_base_i,
	input coord_t hres_i,

	output logic out_stb_o,
	input logic out_ack_i,
	output pix_adr_t out_pix_o
);

	localparam int adr_w = fml_depth - 1;

	logic accept;
	logic [adr_w-1:0] row_off;
	logic [adr_w-1:0] adr_calc;

	// widen both factors first so the product is not cut to 11 bits
	assign row_off = adr_w'(in_pix_i.y) * adr_w'(hres_i);
	assign adr_calc = fb_base_i + row_off + adr_w'(in_pix_i.x);

	// the register takes a new pixel when it is empty or its content leaves this cycle
	assign in_ack_o = ~out_stb_o | out_ack_i;
	assign accept = in_stb_i & in_ack_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			out_stb_o <= 1'b0;
		end else if (in_ack_o) begin
			out_stb_o <= in_stb_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			out_pix_o.color <= in_pix_i.color;
			out_pix_o.adr <= wadr_t'(adr_calc);
		end
	end

	// a stalled pixel must stay put for the fetch stage
	property p_out_hold;
		@(posedge sys_clk) disable iff (sys_rst)
		out_stb_o && !out_ack_i |=> out_stb_o && $stable(out_pix_o);
	endproperty

	a_out_hold: assert property (p_out_hold)
		else $error("address stage output changed under stall");

endmodule

//--- design/dst_blend.sv
// alpha blend stage; alpha is sampled when the pixel is taken and an alpha of 63 still leaves 1/64 of the source out
module dst_blend import pix_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,

	input alpha_t alpha_i,

	input logic in_stb_i,
	output logic in_ack_o,
	input pix_dst_t in_pix_i,

	output logic out_stb_o,
	input logic out_ack_i,
	output pix_out_t out_pix_o,

	output logic busy_o
);

	logic accept;
	logic [4:0] r_mix;
	logic [5:0] g_mix;
	logic [4:0] b_mix;

	// weighted sum of one channel, divided by 64 with truncation
	function automatic logic [5:0] mix(
		input logic [5:0] src,
		input logic [5:0] dst,
		input alpha_t a
	);
		logic [11:0] acc;
		acc = src * a + dst * (6'd63 - a);
		return acc[11:6];
	endfunction

	// red and blue are 5 bits wide, their result never reaches bit 5
	assign r_mix = 5'(mix({1'b0, in_pix_i.color[15:11]}, {1'b0, in_pix_i.dcolor[15:11]},
		alpha_i));
	assign g_mix = mix(in_pix_i.color[10:5], in_pix_i.dcolor[10:5], alpha_i);
	assign b_mix = 5'(mix({1'b0, in_pix_i.color[4:0]}, {1'b0, in_pix_i.dcolor[4:0]},
		alpha_i));

	assign in_ack_o = ~out_stb_o | out_ack_i;
	assign accept = in_stb_i & in_ack_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			out_stb_o <= 1'b0;
		end else if (in_ack_o) begin
			out_stb_o <= in_stb_i;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			out_pix_o.color <= {r_mix, g_mix, b_mix};
			out_pix_o.adr <= in_pix_i.adr;
		end
	end

	assign busy_o = out_stb_o;

	// the consumer may take the result any number of cycles later
	property p_out_hold;
		@(posedge sys_clk) disable iff (sys_rst)
		out_stb_o && !out_ack_i |=> out_stb_o && $stable(out_pix_o);
	endproperty

	a_out_hold: assert property (p_out_hold)
		else $error("blend output changed under stall");

endmodule

//--- design/dst_fetch_top.sv
// destination read path top; fml_depth must be at most 26 and fb_base_i, hres_i and alpha_i are expected to be static
module dst_fetch_top import fml_pkg::*, pix_pkg::*; #(
	parameter int fml_depth = 26
) (
	input logic sys_clk,
	input logic sys_rst,

	input logic pix_stb_i,
	output logic pix_ack_o,
	input pix_xy_t pix_i,

	input logic [fml_depth-2:0] fb_base_i,
	input coord_t hres_i,
	input alpha_t alpha_i,

	input logic flush_i,
	input logic fetch_en_i,

	output fml_req_t fml_req_o,
	input logic fml_ack_i,
	input fml_beat_t fml_di_i,

	output logic out_stb_o,
	input logic out_ack_i,
	output pix_out_t out_pix_o,

	output logic busy_o
);

	// address stage to fetch stage
	logic adr_stb;
	logic adr_ack;
	pix_adr_t adr_pix;

	// fetch stage to blend stage
	logic dst_stb;
	logic dst_ack;
	pix_dst_t dst_pix;

	logic fetch_busy;
	logic blend_busy;

	dst_addr_gen #(
		.fml_depth(fml_depth)
	) addr_gen0 (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.in_stb_i(pix_stb_i),
		.in_ack_o(pix_ack_o),
		.in_pix_i(pix_i),
		.fb_base_i(fb_base_i),
		.hres_i(hres_i),
		.out_stb_o(adr_stb),
		.out_ack_i(adr_ack),
		.out_pix_o(adr_pix)
	);

	dst_line_fetch #(
		.fml_depth(fml_depth)
	) line_fetch0 (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.fml_req_o(fml_req_o),
		.fml_ack_i(fml_ack_i),
		.fml_di_i(fml_di_i),
		.flush_i(flush_i),
		.fetch_en_i(fetch_en_i),
		.busy_o(fetch_busy),
		.in_stb_i(adr_stb),
		.in_ack_o(adr_ack),
		.in_pix_i(adr_pix),
		.out_stb_o(dst_stb),
		.out_ack_i(dst_ack),
		.out_pix_o(dst_pix)
	);

	dst_blend blend0 (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.alpha_i(alpha_i),
		.in_stb_i(dst_stb),
		.in_ack_o(dst_ack),
		.in_pix_i(dst_pix),
		.out_stb_o(out_stb_o),
		.out_ack_i(out_ack_i),
		.out_pix_o(out_pix_o),
		.busy_o(blend_busy)
	);

	// the address stage holds a pixel exactly while its strobe is up
	assign busy_o = adr_stb | fetch_busy | blend_busy;

endmodule

//--- design/dst_line_fetch.sv
// one-line destination cache; fml_depth must be at most 26 and the line is not refetched when memory changes behind it
module dst_line_fetch import fml_pkg::*, pix_pkg::*; #(
	parameter int fml_depth = 26
) (
	input logic sys_clk,
	input logic sys_rst,

	output fml_req_t fml_req_o,
	input logic fml_ack_i,
	input fml_beat_t fml_di_i,

	input logic flush_i,
	input logic fetch_en_i,
	output logic busy_o,

	input logic in_stb_i,
	output logic in_ack_o,
	input pix_adr_t in_pix_i,

	output logic out_stb_o,
	input logic out_ack_i,
	output pix_dst_t out_pix_o
);

	localparam int adr_w = fml_depth - 1;

	typedef enum logic [2:0] {
		idle,
		fetch1,
		fetch2,
		fetch3,
		fetch4,
		out
	} fetch_state_t;

	fetch_state_t state_q;
	fetch_state_t state_d;

	// line tag and held pixel
	logic valid_q;
	logic [adr_w-5:0] tag_q;
	logic wanted_q;
	pix_adr_t pix_q;

	// the cached line, one entry per burst beat
	fml_beat_t line_q [FML_BEATS];
	fml_beat_t beat_rd;
	rgb565_t dcolor;

	logic fetching;
	logic accept;
	logic line_hit;
	logic fill;
	logic tag_we;
	logic line_we;
	logic [1:0] line_wa;

	assign fetching = (state_q == fetch1) || (state_q == fetch2) ||
		(state_q == fetch3) || (state_q == fetch4);

	// a flush in the same cycle already counts as a miss
	assign line_hit = valid_q && !flush_i && (tag_q == in_pix_i.adr[adr_w-1:4]);

	assign in_ack_o = !fetching && (!wanted_q || out_ack_i);
	assign accept = in_stb_i && in_ack_o;

	// hit or miss is decided on the way in, so a fill starts on the next cycle
	assign fill = accept && fetch_en_i && !line_hit;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state_q <= idle;
			wanted_q <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (in_ack_o) begin
				wanted_q <= in_stb_i;
			end
			if (tag_we) begin
				valid_q <= 1'b1;
			end
			if (flush_i) begin
				valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			pix_q <= in_pix_i;
		end
		if (tag_we) begin
			tag_q <= pix_q.adr[adr_w-1:4];
		end
		if (line_we) begin
			line_q[line_wa] <= fml_di_i;
		end
	end

	always_comb begin
		state_d = state_q;
		tag_we = 1'b0;
		line_we = 1'b0;
		line_wa = 2'd0;
		unique case (state_q)
			idle, out: begin
				if (fill) begin
					state_d = fetch1;
				end else if (out_ack_i) begin
					state_d = idle;
				end
			end
			fetch1: begin
				// beat 0 comes with the acknowledge
				if (fml_ack_i) begin
					line_we = 1'b1;
					state_d = fetch2;
				end
			end
			fetch2: begin
				line_we = 1'b1;
				line_wa = 2'd1;
				state_d = fetch3;
			end
			fetch3: begin
				line_we = 1'b1;
				line_wa = 2'd2;
				state_d = fetch4;
			end
			fetch4: begin
				line_we = 1'b1;
				line_wa = 2'd3;
				tag_we = 1'b1;
				state_d = out;
			end
			default: begin
				state_d = idle;
			end
		endcase
	end

	always_comb begin
		fml_req_o = '0;
		fml_req_o.stb = (state_q == fetch1);
		fml_req_o.adr[fml_depth-1:0] = {pix_q.adr[adr_w-1:4], 5'd0};
	end

	// address bits 3:2 pick the beat, bits 1:0 the word within it
	assign beat_rd = line_q[pix_q.adr[3:2]];

	always_comb begin
		unique case (pix_q.adr[1:0])
			2'd0: dcolor = beat_rd[63:48];
			2'd1: dcolor = beat_rd[47:32];
			2'd2: dcolor = beat_rd[31:16];
			default: dcolor = beat_rd[15:0];
		endcase
	end

	assign out_stb_o = wanted_q && !fetching;
	assign out_pix_o = '{color: pix_q.color, adr: pix_q.adr, dcolor: dcolor};
	assign busy_o = wanted_q;

	property p_fml_hold;
		@(posedge sys_clk) disable iff (sys_rst)
		fml_req_o.stb && !fml_ack_i |=> fml_req_o.stb && $stable(fml_req_o.adr);
	endproperty

	a_fml_hold: assert property (p_fml_hold)
		else $error("fml request dropped or moved before acknowledge");

endmodule

//--- design/fml_pkg.sv
// fml bus types; the request address field is sized for a 26-bit memory, so narrower depths leave its upper bits at zero
package fml_pkg;

	// every fill is one burst of this many 64-bit beats
	localparam int FML_BEATS = 4;

	// one data beat, the lowest-addressed 16-bit word sits in bits 63:48
	typedef logic [63:0] fml_beat_t;

	// byte address width at the default memory depth
	localparam int FML_ADR_W = 26;

	// read request to the memory controller
	// stb stays high until the controller acknowledges
	typedef struct packed {
		logic stb;
		logic [FML_ADR_W-1:0] adr;
	} fml_req_t;

endpackage

//--- design/pix_pkg.sv
// pixel types for the destination read path; word addresses are sized for a 26-bit memory and zero-extended below that
package pix_pkg;

	// red in 15:11, green in 10:5, blue in 4:0
	typedef logic [15:0] rgb565_t;

	// screen coordinate, up to 2047
	typedef logic [10:0] coord_t;

	// blend weight of the source colour, 0 to 63
	typedef logic [5:0] alpha_t;

	// framebuffer address in 16-bit words
	typedef logic [24:0] wadr_t;

	// pixel entering the address stage
	typedef struct packed {
		rgb565_t color;
		coord_t x;
		coord_t y;
	} pix_xy_t;

	// pixel with its framebuffer word address
	typedef struct packed {
		rgb565_t color;
		wadr_t adr;
	} pix_adr_t;

	// pixel with the destination colour read from the framebuffer
	typedef struct packed {
		rgb565_t color;
		wadr_t adr;
		rgb565_t dcolor;
	} pix_dst_t;

	// blended pixel leaving the unit
	typedef struct packed {
		rgb565_t color;
		wadr_t adr;
	} pix_out_t;

endpackage

//--- tests/tb_checker.sv
// scoreboard for the destination read path; fb_base, hres, alpha, fetch_en and flush may only change while the unit is idle
module tb_checker import fml_pkg::*, pix_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic pix_stb_i,
	input logic pix_ack_i,
	input pix_xy_t pix_i,
	input wadr_t fb_base_i,
	input coord_t hres_i,
	input alpha_t alpha_i,
	input logic flush_i,
	input logic fetch_en_i,
	input fml_req_t fml_req_i,
	input logic fml_ack_i,
	input logic out_stb_i,
	input logic out_ack_i,
	input pix_out_t out_pix_i,
	output int err_cnt_o,
	output int out_cnt_o,
	output int fml_cnt_o,
	output int exp_pend_o,
	output int req_pend_o
);

	// expected pixels in input order, and whether their colour is known
	pix_out_t exp_q[$];
	logic chk_q[$];
	// expected burst addresses, from a model of the line tag
	logic [FML_ADR_W-1:0] req_q[$];
	logic model_valid = 1'b0;
	logic [20:0] model_line;
	int err_cnt = 0;
	int out_cnt = 0;
	int fml_cnt = 0;

	// address from the screen position, destination word from the memory pattern,
	// then each channel weighted by alpha and 63 - alpha and divided by 64
	function automatic pix_out_t ref_pixel(input pix_xy_t p, input wadr_t base,
		input coord_t hres, input alpha_t a);
		pix_out_t r;
		longint adr;
		logic [15:0] d;
		int w;
		adr = longint'(base) + longint'(p.y) * longint'(hres) + longint'(p.x);
		r.adr = wadr_t'(adr);
		d = r.adr[15:0] ^ 16'h5a5a;
		w = int'(a);
		r.color[15:11] = 5'((int'(p.color[15:11]) * w + int'(d[15:11]) * (63 - w)) / 64);
		r.color[10:5] = 6'((int'(p.color[10:5]) * w + int'(d[10:5]) * (63 - w)) / 64);
		r.color[4:0] = 5'((int'(p.color[4:0]) * w + int'(d[4:0]) * (63 - w)) / 64);
		return r;
	endfunction

	always @(posedge sys_clk) begin : compare
		pix_out_t exp;
		logic chk;
		logic [20:0] line;
		if (sys_rst) begin
			exp_q.delete();
			chk_q.delete();
			req_q.delete();
			model_valid = 1'b0;
		end else begin
			if (flush_i) begin
				model_valid = 1'b0;
			end
			if (pix_stb_i && pix_ack_i) begin
				exp = ref_pixel(pix_i, fb_base_i, hres_i, alpha_i);
				exp_q.push_back(exp);
				chk_q.push_back(fetch_en_i);
				line = exp.adr[24:4];
				// a new line only costs a burst when reads are enabled
				if (fetch_en_i && (!model_valid || line != model_line)) begin
					req_q.push_back({line, 5'd0});
				end
				if (fetch_en_i) begin
					model_valid = 1'b1;
					model_line = line;
				end
			end
			if (fml_req_i.stb && fml_ack_i) begin
				fml_cnt++;
				if (req_q.size() == 0) begin
					$display("ERROR %0t: FML request at %h was not expected", $time,
						fml_req_i.adr);
					err_cnt++;
				end else if (req_q.pop_front() != fml_req_i.adr) begin
					$display("ERROR %0t: FML request %0d at wrong address %h", $time,
						fml_cnt, fml_req_i.adr);
					err_cnt++;
				end
			end
			if (out_stb_i && out_ack_i) begin
				out_cnt++;
				if (exp_q.size() == 0) begin
					$display("ERROR %0t: output pixel at %h without a matching input",
						$time, out_pix_i.adr);
					err_cnt++;
				end else begin
					exp = exp_q.pop_front();
					chk = chk_q.pop_front();
					if (out_pix_i.adr != exp.adr) begin
						$display("ERROR %0t: output %0d has address %h, expected %h",
							$time, out_cnt, out_pix_i.adr, exp.adr);
						err_cnt++;
					end else if (chk && out_pix_i.color != exp.color) begin
						$display("ERROR %0t: output %0d at %h has colour %h, expected %h",
							$time, out_cnt, exp.adr, out_pix_i.color, exp.color);
						err_cnt++;
					end
				end
			end
		end
		err_cnt_o <= err_cnt;
		out_cnt_o <= out_cnt;
		fml_cnt_o <= fml_cnt;
		exp_pend_o <= exp_q.size();
		req_pend_o <= req_q.size();
	end

endmodule

//--- tests/tb_top.sv
// testbench top; memory holds word address xor 5a5a and fb_base, hres, alpha and fetch_en change only between tests
module tb_top import fml_pkg::*, pix_pkg::*; ();

	localparam int fml_depth = 26;
	localparam int clk_period = 4;
	// pixels sent over all tests, sets the watchdog limit
	localparam int total_pix = 179;
	localparam int limit_cycles = total_pix * 40 + 1000;

	logic sys_clk;
	logic sys_rst;
	logic pix_stb_i;
	logic pix_ack_o;
	pix_xy_t pix_i;
	logic [fml_depth-2:0] fb_base_i;
	coord_t hres_i;
	alpha_t alpha_i;
	logic flush_i;
	logic fetch_en_i;
	fml_req_t fml_req_o;
	logic fml_ack_i;
	fml_beat_t fml_di_i;
	logic out_stb_o;
	logic out_ack_i;
	pix_out_t out_pix_o;
	logic busy_o;

	int chk_err;
	int out_cnt;
	int fml_cnt;
	int exp_pend;
	int req_pend;

	integer seed = 32'hd0ba;
	logic stall_en = 1'b0;
	int test_num = 0;
	int test_fail = 0;
	int local_err = 0;
	int err_mark;
	int fml_mark;

	dst_fetch_top #(
		.fml_depth(fml_depth)
	) dut0 (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.pix_stb_i(pix_stb_i), .pix_ack_o(pix_ack_o), .pix_i(pix_i),
		.fb_base_i(fb_base_i), .hres_i(hres_i), .alpha_i(alpha_i),
		.flush_i(flush_i), .fetch_en_i(fetch_en_i),
		.fml_req_o(fml_req_o), .fml_ack_i(fml_ack_i), .fml_di_i(fml_di_i),
		.out_stb_o(out_stb_o), .out_ack_i(out_ack_i), .out_pix_o(out_pix_o),
		.busy_o(busy_o)
	);

	tb_checker chk0 (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.pix_stb_i(pix_stb_i), .pix_ack_i(pix_ack_o), .pix_i(pix_i),
		.fb_base_i(fb_base_i), .hres_i(hres_i), .alpha_i(alpha_i),
		.flush_i(flush_i), .fetch_en_i(fetch_en_i),
		.fml_req_i(fml_req_o), .fml_ack_i(fml_ack_i),
		.out_stb_i(out_stb_o), .out_ack_i(out_ack_i), .out_pix_i(out_pix_o),
		.err_cnt_o(chk_err), .out_cnt_o(out_cnt), .fml_cnt_o(fml_cnt),
		.exp_pend_o(exp_pend), .req_pend_o(req_pend)
	);

	initial begin : clock_gen
		sys_clk = 1'b0;
		forever #(clk_period / 2) sys_clk = ~sys_clk;
	end

	// four consecutive words per beat, the lowest address in the top bits
	function automatic fml_beat_t mem_beat(input logic [FML_ADR_W-1:0] byte_adr, input int k);
		fml_beat_t beat;
		logic [24:0] wa;
		for (int j = 0; j < 4; j++) begin
			wa = byte_adr[FML_ADR_W-1:1] + 25'(4 * k + j);
			beat[63 - 16 * j -: 16] = wa[15:0] ^ 16'h5a5a;
		end
		return beat;
	endfunction

	// memory controller, acknowledges after 0 to 3 cycles and streams the burst
	initial begin : fml_model
		int delay;
		logic [FML_ADR_W-1:0] req_adr;
		forever begin
			@(posedge sys_clk);
			#1;
			if (fml_req_o.stb) begin
				req_adr = fml_req_o.adr;
				delay = {$random(seed)} % 4;
				repeat (delay) begin
					@(posedge sys_clk);
					#1;
				end
				fml_ack_i = 1'b1;
				for (int k = 0; k < FML_BEATS; k++) begin
					fml_di_i = mem_beat(req_adr, k);
					@(posedge sys_clk);
					#1;
					fml_ack_i = 1'b0;
				end
				fml_di_i = '0;
			end
		end
	end

	// the output is taken three cycles in four while stalls are on
	initial begin : out_ack_drive
		forever begin
			@(posedge sys_clk);
			#1;
			if (stall_en) begin
				out_ack_i = ($random(seed) & 3) != 0;
			end else begin
				out_ack_i = 1'b1;
			end
		end
	end

	initial begin : watchdog
		repeat (limit_cycles) @(posedge sys_clk);
		$display("timeout: the unit did not finish within %0d cycles", limit_cycles);
		$display("Verification failed");
		$finish;
	end

	// called one time unit after a rising edge, returns the same way
	task automatic send_pixel(input rgb565_t c, input coord_t x, input coord_t y);
		pix_i = '{color: c, x: x, y: y};
		pix_stb_i = 1'b1;
		do @(posedge sys_clk); while (!pix_ack_o);
		#1;
		pix_stb_i = 1'b0;
	endtask

	task automatic wait_idle();
		do @(posedge sys_clk); while (busy_o);
		@(posedge sys_clk);
		#1;
		if (exp_pend != 0) begin
			$display("test %0d: %0d pixels never came out", test_num + 1, exp_pend);
			local_err++;
		end
		if (req_pend != 0) begin
			$display("test %0d: %0d expected bursts never happened", test_num + 1, req_pend);
			local_err++;
		end
	endtask

	task automatic start_test();
		err_mark = chk_err + local_err;
		fml_mark = fml_cnt;
	endtask

	// n counts the bursts since the start of the test
	task automatic expect_bursts(input int n);
		if (fml_cnt - fml_mark != n) begin
			$display("test %0d: saw %0d FML bursts where %0d were due", test_num + 1,
				fml_cnt - fml_mark, n);
			local_err++;
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = chk_err + local_err - err_mark;
		test_num++;
		if (errs == 0) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			$display("test %0d %s: %0d errors", test_num, name, errs);
			test_fail++;
		end
	endtask

	initial begin : stimulus
		coord_t rx;
		coord_t ry;
		int total_err;
		sys_rst = 1'b1;
		pix_stb_i = 1'b0;
		pix_i = '0;
		fb_base_i = 25'h1000;
		hres_i = 11'd640;
		alpha_i = 6'd32;
		flush_i = 1'b0;
		fetch_en_i = 1'b1;
		fml_ack_i = 1'b0;
		fml_di_i = '0;
		out_ack_i = 1'b1;
		repeat (8) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;

		start_test();
		if (out_stb_o || fml_req_o.stb || busy_o) begin
			$display("test 1: output strobe, FML strobe or busy is high after reset");
			local_err++;
		end
		send_pixel(16'hf800, 11'd3, 11'd2);
		wait_idle();
		expect_bursts(1);
		end_test("reset");

		// all sixteen words of one line, in shuffled order
		start_test();
		alpha_i = 6'd40;
		for (int i = 0; i < 16; i++) begin
			send_pixel(16'h07e0 + 16'(i), coord_t'((i * 5) % 16), 11'd5);
		end
		wait_idle();
		expect_bursts(1);
		end_test("miss then hit");

		start_test();
		alpha_i = 6'd17;
		for (int i = 10; i < 58; i++) begin
			send_pixel(rgb565_t'(i * 977), coord_t'(i), 11'd7);
		end
		wait_idle();
		end_test("line crossing");

		// the line of (57, 7) is still cached from the run before
		start_test();
		send_pixel(16'h001f, 11'd57, 11'd7);
		wait_idle();
		expect_bursts(0);
		flush_i = 1'b1;
		@(posedge sys_clk);
		#1;
		flush_i = 1'b0;
		send_pixel(16'hffff, 11'd56, 11'd7);
		wait_idle();
		expect_bursts(1);
		end_test("flush");

		start_test();
		stall_en = 1'b1;
		for (int b = 0; b < 4; b++) begin
			alpha_i = alpha_t'($random(seed));
			for (int i = 0; i < 24; i++) begin
				rx = coord_t'({$random(seed)} % 640);
				ry = coord_t'({$random(seed)} % 480);
				send_pixel(rgb565_t'($random(seed)), rx, ry);
			end
			wait_idle();
		end
		stall_en = 1'b0;
		end_test("random traffic under stall");

		start_test();
		fetch_en_i = 1'b0;
		for (int i = 0; i < 16; i++) begin
			rx = coord_t'({$random(seed)} % 640);
			ry = coord_t'({$random(seed)} % 480);
			send_pixel(rgb565_t'($random(seed)), rx, ry);
		end
		wait_idle();
		expect_bursts(0);
		fetch_en_i = 1'b1;
		end_test("fetch disabled");

		total_err = chk_err + local_err;
		$display("%0d tests, %0d failed, %0d pixels compared, %0d FML bursts, %0d errors",
			test_num, test_fail, out_cnt, fml_cnt, total_err);
		if (total_err == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
